/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // Sizing
  localparam int LSU_PIPE_NUM = 2;
  localparam int LANE_W       = 1;
  localparam int XLEN_W       = 32;
  localparam int VADDR_W      = 16;
  localparam int PADDR_W      = 12;
  localparam int PAGE_OFS_W   = 8;
  localparam int VPN_W        = 8;
  localparam int PPN_W        = 4;
  localparam int TLB_IDX_W    = 3;
  localparam int TLB_TAG_W    = VPN_W - TLB_IDX_W;
  localparam int DMEM_WORDS   = 256;
  localparam int DMEM_AW      = $clog2(DMEM_WORDS);
  localparam int RNID_W       = 5;
  localparam int SEQ_W        = 6;
  localparam int CNT_W        = 8;
  localparam int HAZ_KIND_NUM = 3;

  typedef enum logic [1:0] {OP_LW, OP_LBU, OP_SW, OP_SB} mem_op_t;

  typedef enum logic [1:0] {HAZ_NONE, HAZ_TLB_MISS, HAZ_MISALIGN, HAZ_RANGE} hazard_t;

  // Operands arrive already read
  typedef struct packed {
    logic              valid;
    mem_op_t           op;
    logic [SEQ_W-1:0]  seq;
    logic [RNID_W-1:0] rd_rnid;
    logic [XLEN_W-1:0] base;
    logic [11:0]       imm12;
    logic [XLEN_W-1:0] st_data;
  } issue_t;

  typedef struct packed {
    logic             valid;
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
  } tlb_wr_t;

  typedef struct packed {
    logic             valid;
    logic [VPN_W-1:0] vpn;
  } tlb_req_t;

  typedef struct packed {
    logic             hit;
    logic [PPN_W-1:0] ppn;
  } tlb_resp_t;

  typedef struct packed {
    logic               valid;
    logic               we;
    logic [DMEM_AW-1:0] word_addr;
    logic [3:0]         be;
    logic [XLEN_W-1:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
    logic [XLEN_W-1:0] rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic               valid;
    logic [SEQ_W-1:0]   seq;
    logic [LANE_W-1:0]  lane;
    hazard_t            hazard;
    logic [VADDR_W-1:0] vaddr;
  } cmpl_t;

endpackage

`default_nettype wire

/* logic/lsu_issue_router.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_router (
  input  logic                                        i_clk,
  input  logic                                        i_reset_n,
  input  lsu_pkg::issue_t                             i_issue,
  output lsu_pkg::issue_t [lsu_pkg::LSU_PIPE_NUM-1:0] o_lane_issue
);

  import lsu_pkg::*;

  logic [LANE_W-1:0]       r_ptr;
  logic [LANE_W-1:0]       w_ptr_next;
  logic [LSU_PIPE_NUM-1:0] w_sel_oh;

  // Lane select for this cycle
  assign w_sel_oh = LSU_PIPE_NUM'(1) << r_ptr;

  always_comb begin
    w_ptr_next = r_ptr;
    if (i_issue.valid) begin
      if (r_ptr == LANE_W'(LSU_PIPE_NUM - 1)) begin
        w_ptr_next = '0;
      end else begin
        w_ptr_next = r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr <= '0;
    end else begin
      r_ptr <= w_ptr_next;
    end
  end

  // Every slot gets the payload, only the selected one is valid
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_lane_issue <= '0;
    end else begin
      for (int i = 0; i < LSU_PIPE_NUM; i++) begin
        o_lane_issue[i]       <= i_issue;
        o_lane_issue[i].valid <= i_issue.valid & w_sel_oh[i];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/lsu_tlb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tlb (
  input  logic                                           i_clk,
  input  logic                                           i_reset_n,
  input  lsu_pkg::tlb_wr_t                               i_tlb_wr,
  input  lsu_pkg::tlb_req_t  [lsu_pkg::LSU_PIPE_NUM-1:0] i_req,
  output lsu_pkg::tlb_resp_t [lsu_pkg::LSU_PIPE_NUM-1:0] o_resp
);

  import lsu_pkg::*;

  localparam int TLB_ENTRIES = 1 << TLB_IDX_W;

  logic [TLB_ENTRIES-1:0] r_valid;
  logic [TLB_TAG_W-1:0]   r_tag [TLB_ENTRIES];
  logic [PPN_W-1:0]       r_ppn [TLB_ENTRIES];

  logic [TLB_IDX_W-1:0]   w_wr_idx;

  // Index is the low VPN bits
  assign w_wr_idx = i_tlb_wr.vpn[TLB_IDX_W-1:0];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_tlb_wr.valid) begin
      r_valid[w_wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_tlb_wr.valid) begin
      r_tag[w_wr_idx] <= i_tlb_wr.vpn[VPN_W-1:TLB_IDX_W];
      r_ppn[w_wr_idx] <= i_tlb_wr.ppn;
    end
  end

  // Combinational lookup per lane
  always_comb begin
    for (int i = 0; i < LSU_PIPE_NUM; i++) begin
      o_resp[i].hit = i_req[i].valid &
                      r_valid[i_req[i].vpn[TLB_IDX_W-1:0]] &
                      (r_tag[i_req[i].vpn[TLB_IDX_W-1:0]] == i_req[i].vpn[VPN_W-1:TLB_IDX_W]);
      o_resp[i].ppn = r_ppn[i_req[i].vpn[TLB_IDX_W-1:0]];
    end
  end

endmodule

`default_nettype wire

/* logic/lsu_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_data_mem (
  input  logic                                                  i_clk,
  input  lsu_pkg::mem_req_t [lsu_pkg::LSU_PIPE_NUM-1:0]         i_req,
  output logic [lsu_pkg::LSU_PIPE_NUM-1:0][lsu_pkg::XLEN_W-1:0] o_rdata
);

  import lsu_pkg::*;

  logic [XLEN_W-1:0] r_mem [DMEM_WORDS];

  // Byte-enabled writes, at most one lane per cycle
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < LSU_PIPE_NUM; i++) begin
      if (i_req[i].valid && i_req[i].we) begin
        for (int b = 0; b < XLEN_W / 8; b++) begin
          if (i_req[i].be[b]) begin
            r_mem[i_req[i].word_addr][b*8 +: 8] <= i_req[i].wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  // Registered read returns pre-write contents
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < LSU_PIPE_NUM; i++) begin
      if (i_req[i].valid && !i_req[i].we) begin
        o_rdata[i] <= r_mem[i_req[i].word_addr];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe #(
  parameter int LANE_IDX = 0
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  lsu_pkg::issue_t               i_issue,
  output lsu_pkg::tlb_req_t             o_tlb_req,
  input  lsu_pkg::tlb_resp_t            i_tlb_resp,
  output lsu_pkg::mem_req_t             o_mem_req,
  input  logic [lsu_pkg::XLEN_W-1:0]    i_mem_rdata,
  output lsu_pkg::phy_wr_t              o_wr,
  output lsu_pkg::cmpl_t                o_cmpl
);

  import lsu_pkg::*;

  issue_t             r_ex1_issue;
  logic [VADDR_W-1:0] w_ex1_vaddr;
  logic [PADDR_W-1:0] w_ex1_paddr;
  logic               w_ex1_is_word;
  logic               w_ex1_is_store;
  hazard_t            w_ex1_haz;

  issue_t             r_ex2_issue;
  hazard_t            r_ex2_haz;
  logic [VADDR_W-1:0] r_ex2_vaddr;
  logic [1:0]         w_ex2_byte_ofs;
  logic [XLEN_W-1:0]  w_ex2_aligned;

  issue_t             r_ex3_issue;
  hazard_t            r_ex3_haz;
  logic [VADDR_W-1:0] r_ex3_vaddr;
  logic [XLEN_W-1:0]  r_ex3_data;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex2_issue <= '0;
      r_ex3_issue <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex2_issue <= r_ex1_issue;
      r_ex3_issue <= r_ex2_issue;
    end
  end

  // EX1 address generation and translation
  assign w_ex1_vaddr = r_ex1_issue.base[VADDR_W-1:0] +
                       {{(VADDR_W-12){r_ex1_issue.imm12[11]}}, r_ex1_issue.imm12};

  assign o_tlb_req.valid = r_ex1_issue.valid;
  assign o_tlb_req.vpn   = w_ex1_vaddr[VADDR_W-1:PAGE_OFS_W];

  assign w_ex1_paddr    = {i_tlb_resp.ppn, w_ex1_vaddr[PAGE_OFS_W-1:0]};
  assign w_ex1_is_word  = (r_ex1_issue.op == OP_LW) || (r_ex1_issue.op == OP_SW);
  assign w_ex1_is_store = (r_ex1_issue.op == OP_SW) || (r_ex1_issue.op == OP_SB);

  // Miss beats misalign beats range
  always_comb begin
    if (!i_tlb_resp.hit) begin
      w_ex1_haz = HAZ_TLB_MISS;
    end else if (w_ex1_is_word && (w_ex1_vaddr[1:0] != 2'b00)) begin
      w_ex1_haz = HAZ_MISALIGN;
    end else if (w_ex1_paddr[PADDR_W-1:DMEM_AW+2] != '0) begin
      w_ex1_haz = HAZ_RANGE;
    end else begin
      w_ex1_haz = HAZ_NONE;
    end
  end

  assign o_mem_req.valid     = r_ex1_issue.valid & (w_ex1_haz == HAZ_NONE);
  assign o_mem_req.we        = w_ex1_is_store;
  assign o_mem_req.word_addr = w_ex1_paddr[DMEM_AW+1:2];
  assign o_mem_req.be        = w_ex1_is_word ? 4'b1111 : (4'b0001 << w_ex1_vaddr[1:0]);
  assign o_mem_req.wdata     = w_ex1_is_word ? r_ex1_issue.st_data :
                               {(XLEN_W/8){r_ex1_issue.st_data[7:0]}};

  // EX2 load alignment
  assign w_ex2_byte_ofs = r_ex2_vaddr[1:0];
  assign w_ex2_aligned  = (r_ex2_issue.op == OP_LBU) ?
                          {{(XLEN_W-8){1'b0}}, i_mem_rdata[w_ex2_byte_ofs*8 +: 8]} :
                          i_mem_rdata;

  always_ff @(posedge i_clk) begin
    r_ex2_haz   <= w_ex1_haz;
    r_ex2_vaddr <= w_ex1_vaddr;
    r_ex3_haz   <= r_ex2_haz;
    r_ex3_vaddr <= r_ex2_vaddr;
    r_ex3_data  <= w_ex2_aligned;
  end

  // EX3 report
  assign o_wr.valid   = r_ex3_issue.valid & (r_ex3_haz == HAZ_NONE) &
                        ((r_ex3_issue.op == OP_LW) || (r_ex3_issue.op == OP_LBU));
  assign o_wr.rd_rnid = r_ex3_issue.rd_rnid;
  assign o_wr.rd_data = r_ex3_data;

  assign o_cmpl.valid  = r_ex3_issue.valid;
  assign o_cmpl.seq    = r_ex3_issue.seq;
  assign o_cmpl.lane   = LANE_W'(LANE_IDX);
  assign o_cmpl.hazard = r_ex3_haz;
  assign o_cmpl.vaddr  = r_ex3_vaddr;

endmodule

`default_nettype wire

/* logic/lsu_cmpl_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_cmpl_merge (
  input  logic                                                        i_clk,
  input  logic                                                        i_reset_n,
  input  lsu_pkg::phy_wr_t [lsu_pkg::LSU_PIPE_NUM-1:0]                i_wr,
  input  lsu_pkg::cmpl_t   [lsu_pkg::LSU_PIPE_NUM-1:0]                i_cmpl,
  output lsu_pkg::phy_wr_t                                            o_wb,
  output lsu_pkg::cmpl_t                                              o_cmpl,
  output logic [lsu_pkg::HAZ_KIND_NUM-1:0][lsu_pkg::CNT_W-1:0]        o_haz_cnt
);

  import lsu_pkg::*;

  phy_wr_t w_wr;
  cmpl_t   w_cmpl;

  // At most one lane is valid per cycle
  always_comb begin
    w_wr   = '0;
    w_cmpl = '0;
    for (int i = 0; i < LSU_PIPE_NUM; i++) begin
      w_wr   = w_wr | (i_wr[i] & {$bits(phy_wr_t){i_wr[i].valid}});
      w_cmpl = w_cmpl | (i_cmpl[i] & {$bits(cmpl_t){i_cmpl[i].valid}});
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb   <= '0;
      o_cmpl <= '0;
    end else begin
      o_wb   <= w_wr;
      o_cmpl <= w_cmpl;
    end
  end

  // Saturating per-kind counters
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_haz_cnt <= '0;
    end else begin
      for (int k = 0; k < HAZ_KIND_NUM; k++) begin
        if (w_cmpl.valid && (w_cmpl.hazard == hazard_t'(k + 1)) &&
            (o_haz_cnt[k] != '1)) begin
          o_haz_cnt[k] <= o_haz_cnt[k] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,
  input  lsu_pkg::issue_t                                      i_issue,
  input  lsu_pkg::tlb_wr_t                                     i_tlb_wr,
  output lsu_pkg::phy_wr_t                                     o_wb,
  output lsu_pkg::cmpl_t                                       o_cmpl,
  output logic [lsu_pkg::HAZ_KIND_NUM-1:0][lsu_pkg::CNT_W-1:0] o_haz_cnt
);

  import lsu_pkg::*;

  issue_t    [LSU_PIPE_NUM-1:0]             w_lane_issue;
  tlb_req_t  [LSU_PIPE_NUM-1:0]             w_tlb_req;
  tlb_resp_t [LSU_PIPE_NUM-1:0]             w_tlb_resp;
  mem_req_t  [LSU_PIPE_NUM-1:0]             w_mem_req;
  logic      [LSU_PIPE_NUM-1:0][XLEN_W-1:0] w_mem_rdata;
  phy_wr_t   [LSU_PIPE_NUM-1:0]             w_lane_wr;
  cmpl_t     [LSU_PIPE_NUM-1:0]             w_lane_cmpl;

  lsu_issue_router u_router (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .o_lane_issue (w_lane_issue)
  );

  for (genvar g = 0; g < LSU_PIPE_NUM; g++) begin : g_lane
    lsu_pipe #(.LANE_IDX(g)) u_pipe (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_issue     (w_lane_issue[g]),
      .o_tlb_req   (w_tlb_req[g]),
      .i_tlb_resp  (w_tlb_resp[g]),
      .o_mem_req   (w_mem_req[g]),
      .i_mem_rdata (w_mem_rdata[g]),
      .o_wr        (w_lane_wr[g]),
      .o_cmpl      (w_lane_cmpl[g])
    );
  end

  lsu_tlb u_tlb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_tlb_wr  (i_tlb_wr),
    .i_req     (w_tlb_req),
    .o_resp    (w_tlb_resp)
  );

  lsu_data_mem u_dmem (
    .i_clk   (i_clk),
    .i_req   (w_mem_req),
    .o_rdata (w_mem_rdata)
  );

  lsu_cmpl_merge u_merge (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr      (w_lane_wr),
    .i_cmpl    (w_lane_cmpl),
    .o_wb      (o_wb),
    .o_cmpl    (o_cmpl),
    .o_haz_cnt (o_haz_cnt)
  );

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  import lsu_pkg::*;

  typedef struct packed {
    logic              is_tlb;
    mem_op_t           op;
    logic [VPN_W-1:0]  vpn;
    logic [PPN_W-1:0]  ppn;
    logic [XLEN_W-1:0] base;
    logic [11:0]       imm;
    logic [XLEN_W-1:0] st_data;
    logic [RNID_W-1:0] rd;
  } row_t;

  typedef struct packed {
    logic [SEQ_W-1:0]   seq;
    logic [LANE_W-1:0]  lane;
    hazard_t            hazard;
    logic [VADDR_W-1:0] vaddr;
    logic               wb_valid;
    logic [RNID_W-1:0]  rd;
    logic [XLEN_W-1:0]  data;
    logic [31:0]        due;
  } expect_t;

  logic                               i_clk;
  logic                               i_reset_n;
  issue_t                             i_issue;
  tlb_wr_t                            i_tlb_wr;
  phy_wr_t                            o_wb;
  cmpl_t                              o_cmpl;
  logic [HAZ_KIND_NUM-1:0][CNT_W-1:0] o_haz_cnt;

  // Reference model state
  logic              m_tlb_valid [8];
  logic [4:0]        m_tlb_tag [8];
  logic [PPN_W-1:0]  m_tlb_ppn [8];
  logic [7:0]        m_mem [4096];
  int                m_cnt [HAZ_KIND_NUM];
  logic [SEQ_W-1:0]  m_seq;
  logic [LANE_W-1:0] m_lane;

  row_t        rows [$];
  expect_t     exp_q [$];
  int          cyc = 0;
  int          errors = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;
  logic [31:0] rng;

  lsu_top i_lsu_top (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .i_tlb_wr  (i_tlb_wr),
    .o_wb      (o_wb),
    .o_cmpl    (o_cmpl),
    .o_haz_cnt (o_haz_cnt)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fill_word(input logic [11:0] pa);
    return {16'hC0DE ^ {4'h0, pa}, 4'h0, pa};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic add_tlb(input logic [7:0] vpn, input logic [3:0] ppn);
    row_t r;
    r = '0;
    r.is_tlb = 1'b1;
    r.vpn    = vpn;
    r.ppn    = ppn;
    rows.push_back(r);
  endtask

  task automatic add_op(input mem_op_t op, input logic [31:0] base, input logic [11:0] imm,
                        input logic [31:0] data, input logic [4:0] rd);
    row_t r;
    r = '0;
    r.op      = op;
    r.base    = base;
    r.imm     = imm;
    r.st_data = data;
    r.rd      = rd;
    rows.push_back(r);
  endtask

  // Expected result of one issue in table order
  task automatic predict(input row_t r, input int issue_cyc);
    expect_t     e;
    logic [15:0] va;
    logic [7:0]  vpn;
    logic [11:0] pa;
    logic        is_word;
    hazard_t     haz;
    va      = r.base[15:0] + {{4{r.imm[11]}}, r.imm};
    vpn     = va[15:8];
    pa      = {m_tlb_ppn[vpn[2:0]], va[7:0]};
    is_word = (r.op == OP_LW) || (r.op == OP_SW);
    if (!m_tlb_valid[vpn[2:0]] || (m_tlb_tag[vpn[2:0]] != vpn[7:3])) begin
      haz = HAZ_TLB_MISS;
    end else if (is_word && (va[1:0] != 2'b00)) begin
      haz = HAZ_MISALIGN;
    end else if (pa >= 12'd1024) begin
      haz = HAZ_RANGE;
    end else begin
      haz = HAZ_NONE;
    end
    e = '0;
    e.seq    = m_seq;
    e.lane   = m_lane;
    e.hazard = haz;
    e.vaddr  = va;
    e.rd     = r.rd;
    // Sampled one edge later and merged four edges after that
    e.due    = issue_cyc + 6;
    if (haz != HAZ_NONE) begin
      if (m_cnt[int'(haz) - 1] < 255) begin
        m_cnt[int'(haz) - 1]++;
      end
    end else if (r.op == OP_SW) begin
      for (int b = 0; b < 4; b++) begin
        m_mem[pa + b] = r.st_data[b*8 +: 8];
      end
    end else if (r.op == OP_SB) begin
      m_mem[pa] = r.st_data[7:0];
    end else if (r.op == OP_LW) begin
      e.wb_valid = 1'b1;
      e.data     = {m_mem[pa + 3], m_mem[pa + 2], m_mem[pa + 1], m_mem[pa]};
    end else begin
      e.wb_valid = 1'b1;
      e.data     = {24'h0, m_mem[pa]};
    end
    m_seq  = m_seq + 1'b1;
    m_lane = (m_lane == LANE_W'(LSU_PIPE_NUM - 1)) ? '0 : m_lane + 1'b1;
    exp_q.push_back(e);
  endtask

  task automatic apply_row(input row_t r);
    issue_t  iss;
    tlb_wr_t tw;
    iss = '0;
    tw  = '0;
    @(posedge i_clk);
    if (r.is_tlb) begin
      tw.valid = 1'b1;
      tw.vpn   = r.vpn;
      tw.ppn   = r.ppn;
      m_tlb_valid[r.vpn[2:0]] = 1'b1;
      m_tlb_tag[r.vpn[2:0]]   = r.vpn[7:3];
      m_tlb_ppn[r.vpn[2:0]]   = r.ppn;
    end else begin
      iss.valid   = 1'b1;
      iss.op      = r.op;
      iss.seq     = m_seq;
      iss.rd_rnid = r.rd;
      iss.base    = r.base;
      iss.imm12   = r.imm;
      iss.st_data = r.st_data;
      predict(r, cyc);
    end
    i_issue  <= iss;
    i_tlb_wr <= tw;
  endtask

  task automatic run_test(input string name);
    int err0;
    int n;
    err0 = errors;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    rows.delete();
    @(posedge i_clk);
    i_issue  <= '0;
    i_tlb_wr <= '0;
    n = 0;
    while ((exp_q.size() > 0) && (n < 50)) begin
      @(posedge i_clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("Timeout in %s: %0d completions never arrived", name, exp_q.size());
      $display("Simulation failed");
      $finish;
    end else begin
      for (int k = 0; k < HAZ_KIND_NUM; k++) begin
        check_value($sformatf("%s hazard count %0d", name, k + 1), o_haz_cnt[k], m_cnt[k]);
      end
      if (errors == err0) begin
        tests_pass++;
        $display("PASS %s", name);
      end else begin
        tests_fail++;
        $display("FAIL %s with %0d errors", name, errors - err0);
      end
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge i_clk) begin
    expect_t e;
    if (i_reset_n && o_cmpl.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected completion at %0t ns with seq %0d", $time, o_cmpl.seq);
      end else begin
        e = exp_q.pop_front();
        check_value("completion seq", o_cmpl.seq, e.seq);
        check_value("completion lane", o_cmpl.lane, e.lane);
        check_value("completion hazard", o_cmpl.hazard, e.hazard);
        check_value("completion vaddr", o_cmpl.vaddr, e.vaddr);
        check_value("completion cycle", cyc, e.due);
        check_value("writeback valid", o_wb.valid, e.wb_valid);
        if (e.wb_valid) begin
          check_value("writeback rd", o_wb.rd_rnid, e.rd);
          check_value("writeback data", o_wb.rd_data, e.data);
        end
      end
    end else if (i_reset_n && o_wb.valid) begin
      errors++;
      $display("Writeback without a completion at %0t ns", $time);
    end
  end

  initial begin
    logic [7:0] vpn;
    i_reset_n = 1'b0;
    i_issue   = '0;
    i_tlb_wr  = '0;
    m_seq     = '0;
    m_lane    = '0;
    rng       = 32'd19212;
    for (int i = 0; i < 8; i++) begin
      m_tlb_valid[i] = 1'b0;
    end
    for (int k = 0; k < HAZ_KIND_NUM; k++) begin
      m_cnt[k] = 0;
    end
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;

    add_tlb(8'h10, 4'h1);
    add_tlb(8'h21, 4'h2);
    add_op(OP_SW, 32'h1000, 12'h010, 32'hDEADBEEF, 5'd1);
    add_op(OP_LW, 32'h1000, 12'h010, 32'h0, 5'd2);
    add_op(OP_SW, 32'h2110, 12'hFF4, 32'h12345678, 5'd3);
    add_op(OP_LW, 32'h2100, 12'h004, 32'h0, 5'd4);
    run_test("store then load word");

    for (int b = 0; b < 4; b++) begin
      add_op(OP_SB, 32'h1020, 12'(b), 32'(8'hA1 + 8'(b * 17)), 5'd0);
    end
    for (int b = 0; b < 4; b++) begin
      add_op(OP_LBU, 32'h1020 + b, 12'h0, 32'h0, 5'(8 + b));
    end
    add_op(OP_LW, 32'h1020, 12'h0, 32'h0, 5'd12);
    run_test("byte stores and loads");

    add_op(OP_SW, 32'h1040, 12'h0, 32'hCAFEF00D, 5'd0);
    add_op(OP_LW, 32'h3300, 12'h0, 32'h0, 5'd5);
    // Same index with another tag makes the old page miss
    add_tlb(8'h50, 4'h1);
    add_op(OP_SW, 32'h1040, 12'h0, 32'h0BADBAD0, 5'd0);
    add_op(OP_LW, 32'h1040, 12'h0, 32'h0, 5'd6);
    add_op(OP_LW, 32'h5040, 12'h0, 32'h0, 5'd7);
    run_test("TLB miss");

    // First page mapped back
    add_tlb(8'h10, 4'h1);
    for (int o = 1; o < 4; o++) begin
      add_op(OP_LW, 32'h1020, 12'(o), 32'h0, 5'd9);
      add_op(OP_SW, 32'h1030, 12'(o), 32'hFFFFFFFF, 5'd0);
      add_op(OP_SB, 32'h1030, 12'(o), 32'(64 + o), 5'd0);
      add_op(OP_LBU, 32'h1030, 12'(o), 32'h0, 5'(o));
    end
    add_tlb(8'h22, 4'h4);
    add_tlb(8'h23, 4'hF);
    add_op(OP_LW, 32'h2200, 12'h0, 32'h0, 5'd10);
    add_op(OP_SB, 32'h2305, 12'h0, 32'h77, 5'd0);
    add_op(OP_LW, 32'h2202, 12'h0, 32'h0, 5'd11);
    add_op(OP_LW, 32'h3301, 12'h0, 32'h0, 5'd13);
    run_test("misalign and range");

    // Known contents for every word the random loads can reach
    for (int w = 0; w < 16; w++) begin
      add_op(OP_SW, 32'h1000 + 4 * w, 12'h0, fill_word(12'h100 + 12'(4 * w)), 5'd0);
      add_op(OP_SW, 32'h2100 + 4 * w, 12'h0, fill_word(12'h200 + 12'(4 * w)), 5'd0);
    end
    for (int i = 0; i < 40; i++) begin
      rng = xorshift(rng);
      case (rng[9:8])
        2'd0:    vpn = 8'h10;
        2'd1:    vpn = 8'h21;
        2'd2:    vpn = 8'h33;
        default: vpn = 8'h22;
      endcase
      add_op(mem_op_t'(rng[11:10]), {16'h0, vpn, 2'b00, rng[5:0]}, 12'h0, ~rng,
             5'(rng[16:12]));
    end
    run_test("random stream");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
    if ((tests_fail == 0) && (errors == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lsu_top.f */
logic/lsu_pkg.sv
logic/lsu_issue_router.sv
logic/lsu_tlb.sv
logic/lsu_data_mem.sv
logic/lsu_pipe.sv
logic/lsu_cmpl_merge.sv
logic/lsu_top.sv
verification/lsu_tb.sv
